//--- design/ucode_macros.svh
// Console controller sizing constants shared by package and RTL

`ifndef UCODE_MACROS_SVH
`define UCODE_MACROS_SVH

// Clocks per clock-enable strobe
`define CLKEN_DIV 4

// Microaddress width in bits
`define UADDR_WIDTH 6

// Words in the control ROM
`define ROM_DEPTH 7

`endif

//--- design/ucodePkg.sv
// Microword types and console special-function encodings

`include "ucode_macros.svh"

package ucodePkg;

   // Special-function select in each microword
   typedef enum logic [1:0]
   {
      SPEC_NOP,
      SPEC_CONS,
      SPEC_DISP_RUN,
      SPEC_DISP_EXEC
   } specSel_t;

   // Console control bits, valid with SPEC_CONS
   typedef struct packed
   {
      logic       setHalt;
      logic       clrHalt;
      logic       clrRun;
      logic       clrExec;
      logic       clrCont;
      logic [2:0] pad;
   } consCtl_t;

   // Shared field, read as console bits or as a dispatch address
   typedef union packed
   {
      consCtl_t   consCtl;
      logic [7:0] target;
   } ucField_t;

   // Full microword, 16 bits
   typedef struct packed
   {
      specSel_t                spec;
      ucField_t                field;
      logic [`UADDR_WIDTH-1:0] nextAddr;
   } ucWord_t;

endpackage

//--- design/ucodeIf.sv
// Bundle between pacing, sequencer, control ROM and console flags

`timescale 1ns/10ps

`include "ucode_macros.svh"

interface ucodeIf import ucodePkg::*; ();

   // Microstep strobe
   logic                    clken;
   // Current microaddress and the word it selects
   logic [`UADDR_WIDTH-1:0] addr;
   ucWord_t                 word;
   // Console status flags
   logic                    cpuRun;
   logic                    cpuCont;
   logic                    cpuExec;
   logic                    cpuHalt;

   modport gen (output clken);

   modport rom (input addr, output word);

   modport seq (input clken, input word, input cpuRun, input cpuExec, output addr);

   modport cons
   (
      input  clken,
      input  word,
      output cpuRun,
      output cpuCont,
      output cpuExec,
      output cpuHalt
   );

endinterface

//--- design/clockGen.sv
// Clock-enable generator, one strobe every CLKEN_DIV clocks

`timescale 1ns/10ps

`include "ucode_macros.svh"

module clockGen
(
   input logic clk,
   input logic rst,
   ucodeIf.gen bus
);

   // Counter wide enough for the reload value, never zero bits
   localparam int cntW = ($clog2(`CLKEN_DIV) > 0) ? $clog2(`CLKEN_DIV) : 1;
   localparam logic [cntW-1:0] reloadVal = cntW'(`CLKEN_DIV - 1);

   logic [cntW-1:0] count;

   //////////////////////////////////////////////////
   // Down-counter
   //////////////////////////////////////////////////

   // Reload at terminal count, else count down
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         count <= '0;
      end
      else if (count == '0)
      begin
         count <= reloadVal;
      end
      else
      begin
         count <= count - 1'b1;
      end
   end

   // Strobe while counter sits at zero
   assign bus.clken = (count == '0);

   // Strobe lasts one clock when dividing
   clkenSingle : assert property (@(posedge clk) disable iff (rst)
      ((`CLKEN_DIV > 1) && bus.clken) |=> !bus.clken)
      else $error("clken high on consecutive clocks");

endmodule

//--- design/controlRom.sv
// Fixed control ROM holding the console idle and service microprogram

`timescale 1ns/10ps

`include "ucode_macros.svh"

module controlRom import ucodePkg::*;
(
   ucodeIf.rom bus
);

   localparam int romAw = ($clog2(`ROM_DEPTH) > 0) ? $clog2(`ROM_DEPTH) : 1;

   ucWord_t romData [`ROM_DEPTH];
   ucWord_t nopWord;

   // Console special-function word
   function automatic ucWord_t consWord
   (
      input logic                    setHalt,
      input logic                    clrHalt,
      input logic                    clrRun,
      input logic                    clrExec,
      input logic                    clrCont,
      input logic [`UADDR_WIDTH-1:0] next
   );
      ucWord_t  w;
      consCtl_t c;
      c         = '0;
      c.setHalt = setHalt;
      c.clrHalt = clrHalt;
      c.clrRun  = clrRun;
      c.clrExec = clrExec;
      c.clrCont = clrCont;
      w.spec          = SPEC_CONS;
      w.field.consCtl = c;
      w.nextAddr      = next;
      return w;
   endfunction

   // Dispatch word, target zero-extended into the field
   function automatic ucWord_t dispWord
   (
      input specSel_t                sel,
      input logic [`UADDR_WIDTH-1:0] target,
      input logic [`UADDR_WIDTH-1:0] next
   );
      ucWord_t w;
      w.spec         = sel;
      w.field.target = '0;
      w.field.target[`UADDR_WIDTH-1:0] = target;
      w.nextAddr     = next;
      return w;
   endfunction

   //////////////////////////////////////////////////
   // Microprogram
   //////////////////////////////////////////////////

   // Power-up halt, then into idle loop
   assign romData[0] = consWord(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 6'd1);
   // Idle loop, wait for run
   assign romData[1] = dispWord(SPEC_DISP_RUN, 6'd2, 6'd1);
   // Leave halt, consume run
   assign romData[2] = consWord(1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 6'd3);
   // Execute or continue
   assign romData[3] = dispWord(SPEC_DISP_EXEC, 6'd5, 6'd4);
   // Continue serviced
   assign romData[4] = consWord(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 6'd6);
   // Execute serviced
   assign romData[5] = consWord(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 6'd6);
   // Back to halt and idle
   assign romData[6] = consWord(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 6'd1);

   // Unpopulated addresses fall back to 0
   assign nopWord = '{spec: SPEC_NOP, field: '0, nextAddr: '0};

   // Combinational read
   assign bus.word = (bus.addr < `ROM_DEPTH) ? romData[bus.addr[romAw-1:0]] : nopWord;

endmodule

//--- design/microSeq.sv
// Microsequencer, steps the microaddress once per clock-enable strobe

`timescale 1ns/10ps

`include "ucode_macros.svh"

module microSeq import ucodePkg::*;
(
   input logic clk,
   input logic rst,
   ucodeIf.seq bus
);

   logic [`UADDR_WIDTH-1:0] dispTarget;
   logic [`UADDR_WIDTH-1:0] nextAddr;

   //////////////////////////////////////////////////
   // Next-address select
   //////////////////////////////////////////////////

   // Dispatch address from the union's target view
   assign dispTarget = bus.word.field.target[`UADDR_WIDTH-1:0];

   // Default is the sequential link
   always_comb
   begin
      nextAddr = bus.word.nextAddr;
      case (bus.word.spec)
         SPEC_DISP_RUN:
         begin
            // Run flag leaves the idle loop
            if (bus.cpuRun)
            begin
               nextAddr = dispTarget;
            end
         end
         SPEC_DISP_EXEC:
         begin
            // Execute takes priority over continue
            if (bus.cpuExec)
            begin
               nextAddr = dispTarget;
            end
         end
         default:
         begin
            nextAddr = bus.word.nextAddr;
         end
      endcase
   end

   //////////////////////////////////////////////////
   // Microprogram counter
   //////////////////////////////////////////////////

   // One microstep per strobe
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         bus.addr <= '0;
      end
      else if (bus.clken)
      begin
         bus.addr <= nextAddr;
      end
   end

   // ROM links and dispatch targets stay inside the program
   addrInRange : assert property (@(posedge clk) disable iff (rst)
      bus.addr < `ROM_DEPTH)
      else $error("microaddress %0h beyond ROM", bus.addr);

endmodule

//--- design/consoleIntf.sv
// Console status flags, set by switches and cleared or set by microcode

`timescale 1ns/10ps

module consoleIntf import ucodePkg::*;
(
   input logic  clk,
   input logic  rst,
   input logic  cslRun,
   input logic  cslCont,
   input logic  cslExec,
   ucodeIf.cons bus
);

   logic     specCons;
   consCtl_t ctl;

   // Console function decode
   assign specCons = (bus.word.spec == SPEC_CONS);
   assign ctl      = bus.word.field.consCtl;

   //////////////////////////////////////////////////
   // Halt flag
   //////////////////////////////////////////////////

   // Microcode only, set has priority
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         bus.cpuHalt <= 1'b0;
      end
      else if (bus.clken && specCons)
      begin
         if (ctl.setHalt)
         begin
            bus.cpuHalt <= 1'b1;
         end
         else if (ctl.clrHalt)
         begin
            bus.cpuHalt <= 1'b0;
         end
      end
   end

   //////////////////////////////////////////////////
   // Run, continue and execute flags
   //////////////////////////////////////////////////

   // Switch set beats a microcode clear in the same strobe
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         bus.cpuRun  <= 1'b0;
         bus.cpuCont <= 1'b0;
         bus.cpuExec <= 1'b0;
      end
      else if (bus.clken)
      begin
         // Run
         if (cslRun)
         begin
            bus.cpuRun <= 1'b1;
         end
         else if (specCons && ctl.clrRun)
         begin
            bus.cpuRun <= 1'b0;
         end
         // Continue
         if (cslCont)
         begin
            bus.cpuCont <= 1'b1;
         end
         else if (specCons && ctl.clrCont)
         begin
            bus.cpuCont <= 1'b0;
         end
         // Execute
         if (cslExec)
         begin
            bus.cpuExec <= 1'b1;
         end
         else if (specCons && ctl.clrExec)
         begin
            bus.cpuExec <= 1'b0;
         end
      end
   end

   // ROM never asks for both halt edges at once
   haltExclusive : assert property (@(posedge clk) disable iff (rst)
      (bus.clken && specCons) |-> !(ctl.setHalt && ctl.clrHalt))
      else $error("console word sets and clears halt");

endmodule

//--- design/ctlTop.sv
// Console controller top, pacing, sequencer, ROM and console flags

`timescale 1ns/10ps

`include "ucode_macros.svh"

module ctlTop
(
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    cslRun,
   input  logic                    cslCont,
   input  logic                    cslExec,
   output logic                    cpuRun,
   output logic                    cpuCont,
   output logic                    cpuExec,
   output logic                    cpuHalt,
   output logic [`UADDR_WIDTH-1:0] uAddr
);

   // Shared bus between the blocks
   ucodeIf ucBus ();

   //////////////////////////////////////////////////
   // Blocks
   //////////////////////////////////////////////////

   // Microstep pacing
   clockGen clockGen_inst
   (
      .clk (clk),
      .rst (rst),
      .bus (ucBus.gen)
   );

   // Microprogram store
   controlRom controlRom_inst
   (
      .bus (ucBus.rom)
   );

   // Microprogram counter
   microSeq microSeq_inst
   (
      .clk (clk),
      .rst (rst),
      .bus (ucBus.seq)
   );

   // Console status flags
   consoleIntf consoleIntf_inst
   (
      .clk     (clk),
      .rst     (rst),
      .cslRun  (cslRun),
      .cslCont (cslCont),
      .cslExec (cslExec),
      .bus     (ucBus.cons)
   );

   // Status and microaddress out to the console
   assign cpuRun  = ucBus.cpuRun;
   assign cpuCont = ucBus.cpuCont;
   assign cpuExec = ucBus.cpuExec;
   assign cpuHalt = ucBus.cpuHalt;
   assign uAddr   = ucBus.addr;

endmodule

//--- bench/ctlTb.sv
// Console controller testbench that runs the switch table through idle and service passes

`timescale 1ns/10ps

`include "ucode_macros.svh"

module ctlTb;

   localparam int numSteps = 9;
   // Clocks allowed for any single wait
   localparam int waitLimit = 20 * `CLKEN_DIV;
   localparam logic [`UADDR_WIDTH-1:0] idleAddr = `UADDR_WIDTH'(1);

   // One table row with the switches to press and the flags expected before and after run
   typedef struct packed
   {
      logic pressExec;
      logic pressCont;
      logic preCont;
      logic preExec;
      logic postCont;
      logic postExec;
   } step_t;

   // Exec pass clears exec only and a continue pass clears cont
   localparam step_t steps [numSteps] = '{
      '{1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0},
      '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
      '{1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0},
      '{1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0},
      '{1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0},
      '{1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0},
      '{1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0},
      '{1'b1, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0},
      '{1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0}
   };

   logic                    clk;
   logic                    rst;
   logic                    cslRun;
   logic                    cslCont;
   logic                    cslExec;
   logic                    cpuRun;
   logic                    cpuCont;
   logic                    cpuExec;
   logic                    cpuHalt;
   logic [`UADDR_WIDTH-1:0] uAddr;

   int errorCount;
   int timeoutCount;

   ctlTop ctlTop_inst
   (
      .clk     (clk),
      .rst     (rst),
      .cslRun  (cslRun),
      .cslCont (cslCont),
      .cslExec (cslExec),
      .cpuRun  (cpuRun),
      .cpuCont (cpuCont),
      .cpuExec (cpuExec),
      .cpuHalt (cpuHalt),
      .uAddr   (uAddr)
   );

   // 20 ns period
   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   //////////////////////////////////////////////////
   // Compare tasks
   //////////////////////////////////////////////////

   task automatic checkFlag(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("ERROR %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
         errorCount++;
      end
   endtask

   task automatic checkAddr(input string name, input logic [`UADDR_WIDTH-1:0] got,
                            input logic [`UADDR_WIDTH-1:0] exp);
      if (got !== exp)
      begin
         $display("ERROR %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
         errorCount++;
      end
   endtask

   task automatic checkFlags(input logic run, input logic cont, input logic exec,
                             input logic halt);
      checkFlag("cpuRun", cpuRun, run);
      checkFlag("cpuCont", cpuCont, cont);
      checkFlag("cpuExec", cpuExec, exec);
      checkFlag("cpuHalt", cpuHalt, halt);
   endtask

   //////////////////////////////////////////////////
   // Waits and switch presses
   //////////////////////////////////////////////////

   // Idle loop with halt up and run consumed
   task automatic waitIdle(input string what);
      int n;
      n = 0;
      while (!(uAddr == idleAddr && cpuHalt && !cpuRun) && n < waitLimit)
      begin
         @(negedge clk);
         n++;
      end
      if (n >= waitLimit)
      begin
         $display("Timeout: idle loop not reached, %s", what);
         timeoutCount++;
      end
   endtask

   // Sequencer must leave address 1 after a run press
   task automatic waitLeaveIdle();
      int n;
      n = 0;
      while (uAddr == idleAddr && n < waitLimit)
      begin
         @(negedge clk);
         n++;
      end
      if (n >= waitLimit)
      begin
         $display("Timeout: microsequencer never left the idle loop after run");
         timeoutCount++;
      end
   endtask

   // Stay idle with flags frozen for a number of strobes
   task automatic holdIdle(input int strobes, input logic cont, input logic exec);
      repeat (strobes * `CLKEN_DIV)
      begin
         @(negedge clk);
         checkAddr("uAddr", uAddr, idleAddr);
         checkFlags(1'b0, cont, exec, 1'b1);
      end
   endtask

   // Held exactly one strobe long
   task automatic pressSwitches(input logic exec, input logic cont);
      cslExec = exec;
      cslCont = cont;
      repeat (`CLKEN_DIV) @(negedge clk);
      cslExec = 1'b0;
      cslCont = 1'b0;
   endtask

   // Run switch held for one strobe
   task automatic pressRun();
      cslRun = 1'b1;
      repeat (`CLKEN_DIV) @(negedge clk);
      cslRun = 1'b0;
   endtask

   //////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////

   initial
   begin
      rst          = 1'b1;
      cslRun       = 1'b0;
      cslCont      = 1'b0;
      cslExec      = 1'b0;
      errorCount   = 0;
      timeoutCount = 0;
      repeat (5) @(negedge clk);
      rst = 1'b0;

      // Power-up microword sets halt before the idle loop
      waitIdle("after reset");
      checkFlags(1'b0, 1'b0, 1'b0, 1'b1);
      holdIdle(20, 1'b0, 1'b0);

      for (int i = 0; i < numSteps; i++)
      begin
         if (steps[i].pressExec || steps[i].pressCont)
         begin
            pressSwitches(steps[i].pressExec, steps[i].pressCont);
            checkFlags(1'b0, steps[i].preCont, steps[i].preExec, 1'b1);
            // Flags must wait for run
            holdIdle(2, steps[i].preCont, steps[i].preExec);
         end
         pressRun();
         // Run latched on the strobe, sequencer not yet moved
         checkFlag("cpuRun", cpuRun, 1'b1);
         waitLeaveIdle();
         waitIdle($sformatf("after run pass of row %0d", i));
         checkFlags(1'b0, steps[i].postCont, steps[i].postExec, 1'b1);
      end

      $display("Errors %0d, timeouts %0d", errorCount, timeoutCount);
      if (errorCount == 0 && timeoutCount == 0)
      begin
         $display("test passed");
      end
      else
      begin
         $display("test failed");
      end
      $finish;
   end

endmodule

//--- compile.f
+incdir+design
design/ucodePkg.sv
design/ucodeIf.sv
design/clockGen.sv
design/controlRom.sv
design/microSeq.sv
design/consoleIntf.sv
design/ctlTop.sv
bench/ctlTb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = ctlTb
FILELIST = compile.f
OBJDIR   = obj_dir

.PHONY: sim clean

# Build, run, and pass only if the pass line appears in the output
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -q "^test passed$$"

clean:
	rm -rf $(OBJDIR)
